/* design/delay_timer.sv */
/*
 * write timing control of the GPRF port bridge
 * delay counter with halt and ALU-done overrides,
 * halt flag and write phase decode
 */
`timescale 1ns/1ns
`include "gprf_bridge_settings.svh"

module delay_timer import gprf_bridge_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_b,
	input  logic                   t_cs,
	input  logic                   delay_sel,
	input  logic [`GPRF_DLY_W-1:0] delay,
	input  logic                   halt_req,
	input  logic                   alu_done,
	output write_phase_e           write_phase
);

	logic [`GPRF_DLY_W-1:0] count;
	logic                   halt;
	logic                   cnt_zero;

	assign cnt_zero = (count == '0);

	// ------------------------------------------------------------
	// counter, first matching rule wins
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			count <= '0;
		end else if (halt_req && cnt_zero) begin
			// parked at zero while halted
			count <= '0;
		end else if (alu_done) begin
			// multi-cycle op finished, go to source phase
			count <= `GPRF_DLY_W'd1;
		end else if (t_cs && !delay_sel) begin
			// wraps from 0 to all ones
			count <= count - `GPRF_DLY_W'd1;
		end else if (t_cs && delay_sel) begin
			count <= delay;
		end
	end

	// halt seen at count zero, refreshed every cycle
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			halt <= 1'b0;
		end else begin
			halt <= halt_req && cnt_zero;
		end
	end

	// phase decode
	always_comb begin
		if (halt) begin
			write_phase = PHASE_IDLE;
		end else if (cnt_zero) begin
			write_phase = PHASE_DST;
		end else if (count == `GPRF_DLY_W'd1) begin
			write_phase = PHASE_SRC;
		end else begin
			write_phase = PHASE_IDLE;
		end
	end

endmodule

/* design/gprf_bridge.sv */
/*
 * GPRF port bridge top level
 * delay timer, select latch and operand pipe
 */
`timescale 1ns/1ns
`include "gprf_bridge_settings.svh"

module gprf_bridge import gprf_bridge_pkg::*; (
	input  logic                         clk,
	input  logic                         reset_b,
	input  logic                         t_cs,
	// decoder timing and control
	input  logic                         delay_sel,
	input  logic [`GPRF_DLY_W-1:0]       delay,
	input  logic                         halt_req,
	input  logic                         alu_done,
	// decoder register selects
	input  dec_sel_t                     src_sel,
	input  dec_sel_t                     dst_sel,
	input  logic                         dst_rmod_t_sel,
	// decoder operand controls
	input  logic                         imm_en,
	input  logic [`GPRF_IMM_W-1:0]       imm,
	input  logic                         mem_load_b,
	input  logic                         indir_addr_sel,
	// data RAM and GPRF read data
	input  logic [`GPRF_MEM_W-1:0]       dram_rdata,
	input  logic [`GPRF_DAT_W-1:0]       gprf_rdata1,
	input  logic [`GPRF_DAT_W-1:0]       gprf_rdata2,
	// toward the register file
	output logic [`GPRF_NUM_REGS-1:0]    bus1_r_sel,
	output logic [`GPRF_NUM_REGS-1:0]    bus2_r_sel,
	output gprf_wsel_t                   gprf_wsel,
	output logic [`GPRF_DAT_W-1:0]       gprf_wdata,
	// toward the data RAM
	output logic [`GPRF_MEM_W-1:0]       dram_wdata,
	output logic [`GPRF_DMEM_ADDR_W-1:0] dram_addr
);

	write_phase_e write_phase;

	delay_timer timer_i (
		.clk         (clk),
		.reset_b     (reset_b),
		.t_cs        (t_cs),
		.delay_sel   (delay_sel),
		.delay       (delay),
		.halt_req    (halt_req),
		.alu_done    (alu_done),
		.write_phase (write_phase)
	);

	select_latch sel_i (
		.clk            (clk),
		.reset_b        (reset_b),
		.t_cs           (t_cs),
		.delay_sel      (delay_sel),
		.src_sel        (src_sel),
		.dst_sel        (dst_sel),
		.dst_rmod_t_sel (dst_rmod_t_sel),
		.write_phase    (write_phase),
		.bus1_r_sel     (bus1_r_sel),
		.bus2_r_sel     (bus2_r_sel),
		.gprf_wsel      (gprf_wsel)
	);

	operand_pipe opnd_i (
		.clk            (clk),
		.reset_b        (reset_b),
		.t_cs           (t_cs),
		.imm_en         (imm_en),
		.imm            (imm),
		.mem_load_b     (mem_load_b),
		.indir_addr_sel (indir_addr_sel),
		.dram_rdata     (dram_rdata),
		.gprf_rdata1    (gprf_rdata1),
		.gprf_rdata2    (gprf_rdata2),
		.gprf_wdata     (gprf_wdata),
		.dram_wdata     (dram_wdata),
		.dram_addr      (dram_addr)
	);

endmodule

/* design/gprf_bridge_pkg.sv */
/*
 * shared types of the GPRF port bridge
 * decoder select struct, GPRF write select struct,
 * write phase and write-back source enums
 */
`include "gprf_bridge_settings.svh"

package gprf_bridge_pkg;

	// one decoder operand, read and write one-hot selects
	typedef struct packed {
		logic [`GPRF_NUM_REGS-1:0] r_sel;
		logic [`GPRF_NUM_REGS-1:0] t_sel;
	} dec_sel_t;

	// write selects toward the register file
	typedef struct packed {
		logic [`GPRF_NUM_REGS-1:0] t_sel;
		logic                      rmod_t_sel;
	} gprf_wsel_t;

	// which stored selects may write this cycle
	typedef enum logic [1:0] {
		PHASE_DST  = 2'd0,
		PHASE_SRC  = 2'd1,
		PHASE_IDLE = 2'd2
	} write_phase_e;

	// write-back data source, highest priority first
	typedef enum logic [1:0] {
		WB_IMM  = 2'd0,
		WB_DRAM = 2'd1,
		WB_GPRF = 2'd2
	} wb_src_e;

endpackage

/* design/gprf_bridge_settings.svh */
/*
 * widths and stage depths for the GPRF port bridge
 * register count, data and address widths, timer width
 */
`ifndef GPRF_BRIDGE_SETTINGS_SVH
`define GPRF_BRIDGE_SETTINGS_SVH

// register file and memory geometry
`define GPRF_NUM_REGS     8
`define GPRF_DAT_W        16
`define GPRF_MEM_W        16
`define GPRF_IMM_W        16
`define GPRF_DMEM_ADDR_W  10

// write timer
`define GPRF_DLY_W        4

// operand staging depths, both at least 2
`define GPRF_IMM_STAGES   2
`define GPRF_LOAD_STAGES  5

`endif

/* design/operand_pipe.sv */
/*
 * operand staging of the GPRF port bridge
 * capture registers, immediate and load delay lines,
 * write-back mux, data RAM write data and indirect address
 */
`timescale 1ns/1ns
`include "gprf_bridge_settings.svh"

module operand_pipe import gprf_bridge_pkg::*; (
	input  logic                         clk,
	input  logic                         reset_b,
	input  logic                         t_cs,
	input  logic                         imm_en,
	input  logic [`GPRF_IMM_W-1:0]       imm,
	input  logic                         mem_load_b,
	input  logic                         indir_addr_sel,
	input  logic [`GPRF_MEM_W-1:0]       dram_rdata,
	input  logic [`GPRF_DAT_W-1:0]       gprf_rdata1,
	input  logic [`GPRF_DAT_W-1:0]       gprf_rdata2,
	output logic [`GPRF_DAT_W-1:0]       gprf_wdata,
	output logic [`GPRF_MEM_W-1:0]       dram_wdata,
	output logic [`GPRF_DMEM_ADDR_W-1:0] dram_addr
);

	localparam int IS = `GPRF_IMM_STAGES;
	localparam int LS = `GPRF_LOAD_STAGES;

	// single capture stage
	logic [`GPRF_MEM_W-1:0] dram_q;
	logic [`GPRF_DAT_W-1:0] rdata1_q;
	logic [`GPRF_DAT_W-1:0] rdata2_q;

	// delay lines, index 0 is the newest
	logic [IS-1:0][`GPRF_IMM_W-1:0] imm_q;
	logic [IS-1:0]                  imm_en_q;
	logic [IS-1:0]                  indir_q;
	logic [LS-1:0]                  load_b_q;

	wb_src_e wb_src;

	// ------------------------------------------------------------
	// staging, frozen while t_cs is low
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			dram_q   <= '0;
			rdata1_q <= '0;
			rdata2_q <= '0;
			imm_q    <= '0;
			imm_en_q <= '0;
			indir_q  <= '0;
			// load flag is active low
			load_b_q <= '1;
		end else if (t_cs) begin
			dram_q   <= dram_rdata;
			rdata1_q <= gprf_rdata1;
			rdata2_q <= gprf_rdata2;
			imm_q    <= {imm_q[IS-2:0], imm};
			imm_en_q <= {imm_en_q[IS-2:0], imm_en};
			indir_q  <= {indir_q[IS-2:0], indir_addr_sel};
			load_b_q <= {load_b_q[LS-2:0], mem_load_b};
		end
	end

	// ------------------------------------------------------------
	// write-back source, immediate over load over port 1
	// ------------------------------------------------------------
	always_comb begin
		if (imm_en_q[IS-1]) begin
			wb_src = WB_IMM;
		end else if (!load_b_q[LS-1]) begin
			wb_src = WB_DRAM;
		end else begin
			wb_src = WB_GPRF;
		end
	end

	always_comb begin
		case (wb_src)
			WB_IMM:  gprf_wdata = `GPRF_DAT_W'(imm_q[IS-1]);
			WB_DRAM: gprf_wdata = `GPRF_DAT_W'(dram_q);
			default: gprf_wdata = rdata1_q;
		endcase
	end

	// store data comes from port 1
	assign dram_wdata = `GPRF_MEM_W'(rdata1_q);

	// indirect addressing takes the low bits of port 2
	assign dram_addr = indir_q[IS-1] ? rdata2_q[`GPRF_DMEM_ADDR_W-1:0] : '0;

endmodule

/* design/select_latch.sv */
/*
 * decoder select storage of the GPRF port bridge
 * read select buses and phase-gated GPRF write selects
 */
`timescale 1ns/1ns
`include "gprf_bridge_settings.svh"

module select_latch import gprf_bridge_pkg::*; (
	input  logic                      clk,
	input  logic                      reset_b,
	input  logic                      t_cs,
	input  logic                      delay_sel,
	input  dec_sel_t                  src_sel,
	input  dec_sel_t                  dst_sel,
	input  logic                      dst_rmod_t_sel,
	input  write_phase_e              write_phase,
	output logic [`GPRF_NUM_REGS-1:0] bus1_r_sel,
	output logic [`GPRF_NUM_REGS-1:0] bus2_r_sel,
	output gprf_wsel_t                gprf_wsel
);

	dec_sel_t src_q;
	dec_sel_t dst_q;
	logic     dst_rmod_q;

	// ------------------------------------------------------------
	// capture when a new instruction loads its delay
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			src_q      <= '0;
			dst_q      <= '0;
			dst_rmod_q <= 1'b0;
		end else if (t_cs && delay_sel) begin
			src_q      <= src_sel;
			dst_q      <= dst_sel;
			dst_rmod_q <= dst_rmod_t_sel;
		end
	end

	// read buses straight from the stored selects
	assign bus1_r_sel = src_q.r_sel;
	assign bus2_r_sel = dst_q.r_sel;

	// rmod only goes with the destination write
	always_comb begin
		case (write_phase)
			PHASE_DST: gprf_wsel = '{t_sel: dst_q.t_sel, rmod_t_sel: dst_rmod_q};
			PHASE_SRC: gprf_wsel = '{t_sel: src_q.t_sel, rmod_t_sel: 1'b0};
			default:   gprf_wsel = '0;
		endcase
	end

endmodule

/* dv/gprf_bridge_props.sv */
/*
 * concurrent checks for the GPRF port bridge
 * one-hot write selects, rmod kept out of the source phase,
 * outputs held through a stall, bound into select latch and operand pipe
 */
`timescale 1ns/1ns
`include "gprf_bridge_settings.svh"

module gprf_bridge_props import gprf_bridge_pkg::*; #(
	parameter int W        = 1,
	parameter bit HAS_WSEL = 1'b1
) (
	input logic         clk,
	input logic         reset_b,
	input logic         t_cs,
	input logic [1:0]   phase_bits,
	input gprf_wsel_t   wsel,
	input logic [W-1:0] held
);

	// write select checks where the selects exist
	if (HAS_WSEL) begin : g_wsel_checks
		// at most one register written per cycle
		a_wsel_onehot: assert property (@(posedge clk) disable iff (!reset_b)
			$onehot0(wsel.t_sel))
			else $error("more than one GPRF write select high");

		a_rmod_not_src: assert property (@(posedge clk) disable iff (!reset_b)
			!(wsel.rmod_t_sel && phase_bits == PHASE_SRC))
			else $error("rmod write select high during the source phase");
	end

	// a stall freezes everything unless halt or alu_done moved the phase
	a_stall_hold: assert property (@(posedge clk) disable iff (!reset_b)
		!$past(t_cs) && $stable(phase_bits) |-> $stable(held))
		else $error("outputs changed while t_cs was low");

endmodule

// ------------------------------------------------------------
// attachment points
// ------------------------------------------------------------
bind select_latch gprf_bridge_props #(
	.W(3 * `GPRF_NUM_REGS + 1)
) props_sel_i (
	.clk        (clk),
	.reset_b    (reset_b),
	.t_cs       (t_cs),
	.phase_bits (write_phase),
	.wsel       (gprf_wsel),
	.held       ({bus1_r_sel, bus2_r_sel, gprf_wsel})
);

bind operand_pipe gprf_bridge_props #(
	.W(`GPRF_DAT_W + `GPRF_MEM_W + `GPRF_DMEM_ADDR_W),
	.HAS_WSEL(1'b0)
) props_opnd_i (
	.clk        (clk),
	.reset_b    (reset_b),
	.t_cs       (t_cs),
	.phase_bits (2'b00),
	.wsel       ('0),
	.held       ({gprf_wdata, dram_wdata, dram_addr})
);

/* dv/gprf_bridge_tb.sv */
/*
 * testbench for the GPRF port bridge
 * clock, reset, random and directed stimulus,
 * cycle reference model, output compare and reporting
 */
`timescale 1ns/1ns
`include "gprf_bridge_settings.svh"

module gprf_bridge_tb import gprf_bridge_pkg::*; ();

	localparam int N  = `GPRF_NUM_REGS;
	localparam int DW = `GPRF_DAT_W;
	localparam int MW = `GPRF_MEM_W;
	localparam int AW = `GPRF_DMEM_ADDR_W;
	localparam int IS = `GPRF_IMM_STAGES;
	localparam int LS = `GPRF_LOAD_STAGES;
	localparam logic [`GPRF_DLY_W-1:0] CNT_ONE = 1;

	typedef struct packed {
		logic [N-1:0]  bus1;
		logic [N-1:0]  bus2;
		gprf_wsel_t    wsel;
		logic [DW-1:0] wdata;
		logic [MW-1:0] dwdata;
		logic [AW-1:0] daddr;
	} exp_t;

	logic clk;
	logic reset_b;
	logic t_cs;
	logic delay_sel;
	logic halt_req;
	logic alu_done;
	logic [`GPRF_DLY_W-1:0] delay;
	dec_sel_t src_sel;
	dec_sel_t dst_sel;
	logic dst_rmod_t_sel;
	logic imm_en;
	logic mem_load_b;
	logic indir_addr_sel;
	logic [`GPRF_IMM_W-1:0] imm;
	logic [MW-1:0] dram_rdata;
	logic [DW-1:0] gprf_rdata1;
	logic [DW-1:0] gprf_rdata2;
	logic [N-1:0] bus1_r_sel;
	logic [N-1:0] bus2_r_sel;
	gprf_wsel_t gprf_wsel;
	logic [DW-1:0] gprf_wdata;
	logic [MW-1:0] dram_wdata;
	logic [AW-1:0] dram_addr;

	// reference model state
	logic [`GPRF_DLY_W-1:0] m_cnt;
	logic m_halt;
	dec_sel_t m_src;
	dec_sel_t m_dst;
	logic m_rmod;
	logic [MW-1:0] m_dram;
	logic [DW-1:0] m_rd1;
	logic [DW-1:0] m_rd2;
	logic [`GPRF_IMM_W-1:0] m_imm [IS];
	logic m_imm_en [IS];
	logic m_indir [IS];
	logic m_load_b [LS];

	int errors = 0;
	int checks = 0;

	gprf_bridge dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic void model_reset();
		m_cnt = '0;
		m_halt = 1'b0;
		m_src = '0;
		m_dst = '0;
		m_rmod = 1'b0;
		m_dram = '0;
		m_rd1 = '0;
		m_rd2 = '0;
		for (int i = 0; i < IS; i++) begin
			m_imm[i] = '0;
			m_imm_en[i] = 1'b0;
			m_indir[i] = 1'b0;
		end
		for (int i = 0; i < LS; i++) begin
			m_load_b[i] = 1'b1;
		end
	endfunction

	// one clock edge with the inputs as they are now
	function automatic void advance_model();
		logic [`GPRF_DLY_W-1:0] next_cnt;
		if (!reset_b) begin
			model_reset();
		end else begin
			if (halt_req && m_cnt == '0) next_cnt = '0;
			else if (alu_done) next_cnt = CNT_ONE;
			else if (t_cs && !delay_sel) next_cnt = m_cnt - 1'b1;
			else if (t_cs) next_cnt = delay;
			else next_cnt = m_cnt;
			m_halt = halt_req && (m_cnt == '0);
			m_cnt = next_cnt;
			if (t_cs) begin
				if (delay_sel) begin
					m_src = src_sel;
					m_dst = dst_sel;
					m_rmod = dst_rmod_t_sel;
				end
				for (int i = IS - 1; i > 0; i--) begin
					m_imm[i] = m_imm[i-1];
					m_imm_en[i] = m_imm_en[i-1];
					m_indir[i] = m_indir[i-1];
				end
				for (int i = LS - 1; i > 0; i--) begin
					m_load_b[i] = m_load_b[i-1];
				end
				m_imm[0] = imm;
				m_imm_en[0] = imm_en;
				m_indir[0] = indir_addr_sel;
				m_load_b[0] = mem_load_b;
				m_dram = dram_rdata;
				m_rd1 = gprf_rdata1;
				m_rd2 = gprf_rdata2;
			end
		end
	endfunction

	function automatic exp_t predict();
		exp_t e;
		e.bus1 = m_src.r_sel;
		e.bus2 = m_dst.r_sel;
		e.wsel = '0;
		if (!m_halt && m_cnt == '0) e.wsel = '{t_sel: m_dst.t_sel, rmod_t_sel: m_rmod};
		else if (!m_halt && m_cnt == CNT_ONE) e.wsel.t_sel = m_src.t_sel;
		if (m_imm_en[IS-1]) e.wdata = DW'(m_imm[IS-1]);
		else if (!m_load_b[LS-1]) e.wdata = DW'(m_dram);
		else e.wdata = m_rd1;
		e.dwdata = MW'(m_rd1);
		e.daddr = m_indir[IS-1] ? m_rd2[AW-1:0] : '0;
		return e;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("error: time %0t: %s", $time, msg);
	endtask

	// compare at the falling edge, then step the model for the next rising edge
	initial begin
		exp_t want;
		exp_t got;
		model_reset();
		forever begin
			@(negedge clk);
			want = predict();
			got = '{bus1_r_sel, bus2_r_sel, gprf_wsel, gprf_wdata, dram_wdata, dram_addr};
			checks++;
			if (got !== want) begin
				report_error($sformatf("outputs %p, expected %p", got, want));
			end
			advance_model();
		end
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	function automatic logic [N-1:0] onehot_sel();
		return N'(1) << $urandom_range(N - 1, 0);
	endfunction

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic wait_wsel(input logic [N-1:0] mask, input int limit, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > limit) abort_run($sformatf("%s did not appear in %0d cycles", what, limit));
		end while (gprf_wsel.t_sel !== mask);
	endtask

	task automatic drive_random(input int cycles, input int tcs_pct, input int dsel_pct);
		repeat (cycles) begin
			@(posedge clk);
			t_cs           <= ($urandom % 100) < tcs_pct;
			delay_sel      <= ($urandom % 100) < dsel_pct;
			delay          <= `GPRF_DLY_W'($urandom);
			halt_req       <= ($urandom % 20) == 0;
			alu_done       <= ($urandom % 20) == 0;
			src_sel        <= '{r_sel: onehot_sel(), t_sel: onehot_sel()};
			dst_sel        <= '{r_sel: onehot_sel(), t_sel: onehot_sel()};
			dst_rmod_t_sel <= 1'($urandom);
			imm_en         <= ($urandom % 4) == 0;
			imm            <= `GPRF_IMM_W'($urandom);
			mem_load_b     <= ($urandom % 3) != 0;
			indir_addr_sel <= 1'($urandom);
			dram_rdata     <= MW'($urandom);
			gprf_rdata1    <= DW'($urandom);
			gprf_rdata2    <= DW'($urandom);
		end
	endtask

	task automatic end_test(input string name, input int base);
		@(posedge clk);
		$display("test %s done, %0d errors", name, errors - base);
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		int base;
		logic [N-1:0] s_mask;
		logic [N-1:0] d_mask;
		void'($urandom(11481));
		reset_b = 1'b0;
		t_cs = 1'b0;
		delay_sel = 1'b0;
		delay = '0;
		halt_req = 1'b0;
		alu_done = 1'b0;
		src_sel = '0;
		dst_sel = '0;
		dst_rmod_t_sel = 1'b0;
		imm_en = 1'b0;
		imm = '0;
		mem_load_b = 1'b1;
		indir_addr_sel = 1'b0;
		dram_rdata = '0;
		gprf_rdata1 = '0;
		gprf_rdata2 = '0;
		repeat (10) @(posedge clk);
		reset_b <= 1'b1;

		base = errors;
		@(negedge clk);
		if (bus1_r_sel !== '0 || bus2_r_sel !== '0 || gprf_wsel !== '0 ||
				dram_addr !== '0 || gprf_wdata !== '0) begin
			report_error("outputs not idle after reset");
		end
		end_test("reset state", base);

		base = errors;
		drive_random(300, 90, 10);
		end_test("write-back priority", base);
		base = errors;
		drive_random(200, 70, 10);
		end_test("data RAM path", base);
		base = errors;
		drive_random(200, 60, 40);
		end_test("select latching", base);

		// delay N, source at count 1, destination at 0, alu_done back to 1
		base = errors;
		s_mask = onehot_sel();
		d_mask = {s_mask[N-2:0], s_mask[N-1]};
		@(posedge clk);
		t_cs <= 1'b1;
		halt_req <= 1'b0;
		alu_done <= 1'b0;
		delay_sel <= 1'b1;
		delay <= `GPRF_DLY_W'($urandom_range(8, 3));
		src_sel <= '{r_sel: onehot_sel(), t_sel: s_mask};
		dst_sel <= '{r_sel: onehot_sel(), t_sel: d_mask};
		dst_rmod_t_sel <= 1'b1;
		@(posedge clk);
		delay_sel <= 1'b0;
		wait_wsel(s_mask, 12, "source write select");
		wait_wsel(d_mask, 2, "destination write select");
		if (gprf_wsel.rmod_t_sel !== 1'b1) begin
			report_error("rmod write select missing in the destination phase");
		end
		@(posedge clk);
		alu_done <= 1'b1;
		@(posedge clk);
		alu_done <= 1'b0;
		wait_wsel(s_mask, 3, "source write select after alu_done");
		end_test("delay timing", base);

		// halt at count 0, then release with t_cs low so the count must still be 0
		base = errors;
		@(posedge clk);
		delay_sel <= 1'b1;
		delay <= '0;
		@(posedge clk);
		delay_sel <= 1'b0;
		halt_req <= 1'b1;
		wait_wsel(d_mask, 2, "destination write select at count 0");
		wait_wsel('0, 2, "idle write selects under halt");
		repeat (5) begin
			@(negedge clk);
			if (gprf_wsel !== '0) report_error("write select active while halted");
		end
		@(posedge clk);
		halt_req <= 1'b0;
		t_cs <= 1'b0;
		wait_wsel(d_mask, 3, "destination write select after halt release");
		end_test("halt", base);

		drive_random(20, 80, 20);
		@(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* gprf_bridge.f */
+incdir+design
design/gprf_bridge_pkg.sv
design/delay_timer.sv
design/select_latch.sv
design/operand_pipe.sv
design/gprf_bridge.sv
dv/gprf_bridge_tb.sv
dv/gprf_bridge_props.sv

/* run_sim.sh */
#!/bin/sh
# build and run the GPRF port bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
	--top-module gprf_bridge_tb -f gprf_bridge.f -Mdir obj_dir -o gprf_bridge_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/gprf_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0
